/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= dcache_tb
RTL_TOP   ?= dcache_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

# lint the cache itself with the RTL top level
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# build and run; a $$fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/dcache_ctrl.sv */
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // cpu side
    input  logic                 req,
    input  cpu_req_t             cpu_req,
    output logic                 busy,
    output logic                 rdata_valid,
    output word_t                rdata,
    // ways and selector
    output index_t               index,
    output tag_t                 tag,
    output logic [ASSOC_NUM-1:0] way_we,
    output way_wr_t              way_wr,
    input  logic                 hit,
    input  logic                 victim_way,
    input  logic                 victim_dirty,
    input  line_t                hit_line,
    input  line_t                victim_line,
    input  tag_t                 victim_tag,
    output logic                 touch,
    // memory side
    output logic                 rd_req,
    output addr_t                rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  line_t                ret_line,
    output logic                 wr_req,
    output addr_t                wr_addr,
    output line_t                wr_line,
    input  logic                 wr_rdy,
    input  logic                 wr_done
);

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } state_t;

    state_t    state;
    state_t    state_next;
    cpu_req_t  req_q;
    logic      req_valid;
    logic      lookup_hit;
    word_sel_t word_sel;
    word_t     hit_word;

    assign index    = req_q.addr.f.index;
    assign tag      = req_q.addr.f.tag;
    assign word_sel = req_q.addr.f.offset[OFFSET_WIDTH-1 -: WORD_SEL_W];
    assign hit_word = hit_line[32*word_sel +: 32];

    assign lookup_hit = req_valid && (state == LOOKUP) && hit;

    // free when idle or when the pending lookup completes this cycle
    assign busy        = req_valid && !lookup_hit;
    assign rdata_valid = lookup_hit && !req_q.write;
    assign rdata       = hit_word;
    assign touch       = lookup_hit;

    // lookup stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (!busy) begin
            req_valid <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req && !busy) begin
            req_q <= cpu_req;
        end
    end

    // write commands to the ways
    always_comb begin
        way_wr      = '0;
        way_we      = '0;
        way_wr.tag  = req_q.addr.f.tag;
        way_wr.word = word_sel;
        if (state == REFILL && ret_valid) begin
            way_wr.refill      = 1'b1;
            way_wr.line        = ret_line;
            way_we[victim_way] = 1'b1;
        end else if (lookup_hit && req_q.write) begin
            // every way sees the store, only the hitting one takes it
            way_wr.store = 1'b1;
            way_wr.line  = {LINE_WORD_NUM{merge_bytes(hit_word, req_q.wdata, req_q.wstrb)}};
            way_we       = '1;
        end
    end

    // memory requests
    assign rd_req      = (state == MISS_CLEAN);
    assign rd_addr.raw = {req_q.addr.raw[31:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

    assign wr_req         = (state == MISS_DIRTY);
    assign wr_addr.f.tag    = victim_tag;
    assign wr_addr.f.index  = req_q.addr.f.index;
    assign wr_addr.f.offset = '0;
    assign wr_line        = victim_line;

    // miss handling
    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (req_valid && !hit) begin
                    state_next = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
                end
            end
            MISS_DIRTY: begin
                if (wr_rdy) begin
                    state_next = WRITEBACK;
                end
            end
            WRITEBACK: begin
                if (wr_done) begin
                    state_next = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_next = REFILL_DONE;
                end
            end
            // go round once more so the lookup hits the new line
            REFILL_DONE: state_next = LOOKUP;
            default:     state_next = LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* design/dcache_pkg.sv */
package dcache_pkg;

    // geometry: 2 ways x 64 sets x 16-byte lines
    localparam int ASSOC_NUM     = 2;
    localparam int LINE_WORD_NUM = 4;
    localparam int SET_NUM       = 64;
    localparam int OFFSET_WIDTH  = 4;
    localparam int INDEX_WIDTH   = 6;
    localparam int TAG_WIDTH     = 22;
    localparam int LINE_WIDTH    = 128;
    localparam int WORD_SEL_W    = $clog2(LINE_WORD_NUM);

    typedef logic [TAG_WIDTH-1:0]    tag_t;
    typedef logic [INDEX_WIDTH-1:0]  index_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [31:0]             word_t;
    typedef logic [LINE_WIDTH-1:0]   line_t;
    typedef logic [WORD_SEL_W-1:0]   word_sel_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_fields_t;

    // same 32 bits, seen as a plain word or split into cache fields
    typedef union packed {
        word_t        raw;
        addr_fields_t f;
    } addr_t;

    typedef struct packed {
        logic       write;
        addr_t      addr;
        word_t      wdata;
        logic [3:0] wstrb;
    } cpu_req_t;

    // one way's entry at the lookup index
    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_rd_t;

    // refill writes the full line, store writes one word of it
    typedef struct packed {
        logic      refill;
        logic      store;
        word_sel_t word;
        tag_t      tag;
        line_t     line;
    } way_wr_t;

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input logic [3:0] strb);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

endpackage

/* design/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    input  cpu_req_t cpu_req,
    output logic     busy,
    output logic     rdata_valid,
    output word_t    rdata,
    output logic     rd_req,
    output addr_t    rd_addr,
    input  logic     rd_rdy,
    input  logic     ret_valid,
    input  line_t    ret_line,
    output logic     wr_req,
    output addr_t    wr_addr,
    output line_t    wr_line,
    input  logic     wr_rdy,
    input  logic     wr_done
);

    index_t               index;
    tag_t                 tag;
    logic [ASSOC_NUM-1:0] way_we;
    way_wr_t              way_wr;
    way_rd_t              way_rd [ASSOC_NUM];
    logic                 hit;
    logic                 touch;
    logic                 victim_way;
    logic                 victim_dirty;
    tag_t                 victim_tag;
    line_t                hit_line;
    line_t                victim_line;

    dcache_ctrl u_ctrl (
        .clk, .rst, .req, .cpu_req, .busy, .rdata_valid, .rdata,
        .index, .tag, .way_we, .way_wr,
        .hit, .victim_way, .victim_dirty, .hit_line, .victim_line, .victim_tag, .touch,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_line,
        .wr_req, .wr_addr, .wr_line, .wr_rdy, .wr_done
    );

    for (genvar g = 0; g < ASSOC_NUM; g++) begin : g_way
        dcache_way u_way (
            .clk   (clk),
            .rst   (rst),
            .index (index),
            .we    (way_we[g]),
            .wr    (way_wr),
            .rd    (way_rd[g])
        );
    end

    dcache_way_select u_sel (
        .clk, .rst, .index, .tag, .ways(way_rd), .touch,
        .hit, .hit_line, .victim_way, .victim_dirty, .victim_tag, .victim_line
    );

endmodule

/* design/dcache_way.sv */
`timescale 1ns/10ps

module dcache_way import dcache_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  index_t  index,
    input  logic    we,
    input  way_wr_t wr,
    output way_rd_t rd
);

    logic [SET_NUM-1:0] valid;
    logic [SET_NUM-1:0] dirty;
    tag_t               tag_mem [SET_NUM];
    word_t              data_mem [SET_NUM][LINE_WORD_NUM];
    logic               store_hit;

    // a store lands only in the way that already holds the tag
    assign store_hit = wr.store && valid[index] && (tag_mem[index] == wr.tag);

    // line state bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (we && wr.refill) begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end else if (we && store_hit) begin
            dirty[index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (we && wr.refill) begin
            tag_mem[index] <= wr.tag;
            for (int w = 0; w < LINE_WORD_NUM; w++) begin
                data_mem[index][w] <= wr.line[32*w +: 32];
            end
        end else if (we && store_hit) begin
            data_mem[index][wr.word] <= wr.line[32*wr.word +: 32];
        end
    end

    // combinational read at the lookup index
    always_comb begin
        rd.valid = valid[index];
        rd.dirty = dirty[index];
        rd.tag   = tag_mem[index];
        for (int w = 0; w < LINE_WORD_NUM; w++) begin
            rd.line[32*w +: 32] = data_mem[index][w];
        end
    end

endmodule

/* design/dcache_way_select.sv */
`timescale 1ns/10ps

module dcache_way_select import dcache_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  index_t  index,
    input  tag_t    tag,
    input  way_rd_t ways [ASSOC_NUM],
    input  logic    touch,
    output logic    hit,
    output line_t   hit_line,
    output logic    victim_way,
    output logic    victim_dirty,
    output tag_t    victim_tag,
    output line_t   victim_line
);

    // one bit per set, names the least recently used way
    logic [SET_NUM-1:0]   lru;
    logic [ASSOC_NUM-1:0] hit_vec;
    logic                 hit_way;

    // tag compare
    always_comb begin
        hit_way = 1'b0;
        for (int i = 0; i < ASSOC_NUM; i++) begin
            hit_vec[i] = ways[i].valid && (ways[i].tag == tag);
            if (hit_vec[i]) begin
                hit_way = 1'(i);
            end
        end
    end

    assign hit      = |hit_vec;
    assign hit_line = ways[hit_way].line;

    // victim is whatever the lru bit points at
    assign victim_way   = lru[index];
    assign victim_dirty = ways[victim_way].valid && ways[victim_way].dirty;
    assign victim_tag   = ways[victim_way].tag;
    assign victim_line  = ways[victim_way].line;

    // point the set's bit away from the way just used
    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
        end else if (touch) begin
            lru[index] <= ~hit_way;
        end
    end

endmodule

/* sources.f */
design/dcache_pkg.sv
design/dcache_way.sv
design/dcache_way_select.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

/* tb/dcache_tb.sv */
`timescale 1ns/10ps

module dcache_tb import dcache_pkg::*; ;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 10;
    localparam int    N_RAND       = 400;
    localparam int    TOTAL_REQ    = N_RAND + 8;
    localparam int    MAX_WAIT     = 7;
    localparam int    WORST_MISS   = 2 * (MAX_WAIT + 4) + 6;
    localparam int    MEM_WORDS    = 1024;
    localparam word_t MEM_FILL     = 32'h3c00_0000;
    // three lines of set 45
    localparam word_t REPL_A       = 32'h0000_02d0;
    localparam word_t REPL_B       = 32'h0000_06d0;
    localparam word_t REPL_C       = 32'h0000_0ad0;

    logic     clk;
    logic     rst;
    logic     req;
    cpu_req_t cpu_req;
    logic     busy;
    logic     rdata_valid;
    word_t    rdata;
    logic     rd_req;
    addr_t    rd_addr;
    logic     rd_rdy;
    logic     ret_valid;
    line_t    ret_line;
    logic     wr_req;
    addr_t    wr_addr;
    line_t    wr_line;
    logic     wr_rdy;
    logic     wr_done;

    // reference model and bookkeeping
    word_t        ref_mem [MEM_WORDS];
    logic [255:0] line_stored;
    logic [15:0]  lfsr = 16'd59110;
    word_t        exp_word;
    line_t        exp_wb_line;
    logic         load_pending;
    logic         req_seen;
    logic         last_valid;
    logic [7:0]   last_line;
    logic         check_repl;
    logic         wb_seen;
    logic         accept;
    logic         same_line;
    logic [9:0]   req_word;
    logic [7:0]   req_line;
    logic [7:0]   wb_line;

    dcache_top uut (.*);

    mem_model #(.WORDS(MEM_WORDS), .FILL(MEM_FILL)) u_mem (
        .clk, .rst, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_line,
        .wr_req, .wr_addr, .wr_line, .wr_rdy, .wr_done
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // strobed bytes take the new data
    function automatic word_t apply_strobes(input word_t old_word, input word_t wdata,
                                            input logic [3:0] strb);
        word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (wdata & mask);
    endfunction

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
        stop_run();
    endtask

    task automatic report_problem(input string why);
        $display("%s", why);
        stop_run();
    endtask

    // enter right after a rising edge, leave at the edge that took the request
    task automatic issue(input logic write, input word_t addr, input word_t wdata,
                         input logic [3:0] strb);
        req               <= 1'b1;
        cpu_req.write     <= write;
        cpu_req.addr.raw  <= addr;
        cpu_req.wdata     <= wdata;
        cpu_req.wstrb     <= strb;
        @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);
        req <= 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);
    endtask

    assign accept    = req && !busy;
    assign req_word  = cpu_req.addr.raw[11:2];
    assign req_line  = cpu_req.addr.raw[11:4];
    assign wb_line   = wr_addr.raw[11:4];
    assign same_line = last_valid && (req_line == last_line);

    always_comb begin
        for (int w = 0; w < 4; w++) begin
            exp_wb_line[32*w +: 32] = ref_mem[{wb_line, 2'(w)}];
        end
    end

    // follows every accepted request and write-back
    always @(posedge clk) begin
        if (rst) begin
            load_pending <= 1'b0;
            req_seen     <= 1'b0;
            last_valid   <= 1'b0;
            wb_seen      <= 1'b0;
            line_stored  <= '0;
        end else begin
            if (req) begin
                req_seen <= 1'b1;
            end
            if (rdata_valid) begin
                load_pending <= 1'b0;
            end
            if (accept) begin
                last_valid <= 1'b1;
                last_line  <= req_line;
                if (cpu_req.write) begin
                    ref_mem[req_word]     <= apply_strobes(ref_mem[req_word], cpu_req.wdata,
                                                           cpu_req.wstrb);
                    line_stored[req_line] <= 1'b1;
                end else begin
                    exp_word     <= ref_mem[req_word];
                    load_pending <= 1'b1;
                end
            end
            if (wr_req && wr_rdy) begin
                line_stored[wb_line] <= 1'b0;
            end
            wb_seen <= check_repl && (wb_seen || (wr_req && wr_rdy));
        end
    end

    reset_quiet: assert property (@(posedge clk) disable iff (rst)
        !req_seen |-> !(busy || rdata_valid || rd_req || wr_req))
        else report_mismatch("busy/rdata_valid/rd_req/wr_req",
                             128'($sampled({busy, rdata_valid, rd_req, wr_req})), 128'(0));

    load_data: assert property (@(posedge clk) disable iff (rst)
        rdata_valid |-> rdata == exp_word)
        else report_mismatch("rdata", 128'($sampled(rdata)), 128'($sampled(exp_word)));

    load_owed: assert property (@(posedge clk) disable iff (rst)
        rdata_valid |-> load_pending)
        else report_problem("rdata_valid came with no load waiting for it");

    hit_latency: assert property (@(posedge clk) disable iff (rst)
        accept && !cpu_req.write && same_line |=> rdata_valid)
        else report_problem("load to a resident line did not return data one cycle later");

    wb_data: assert property (@(posedge clk) disable iff (rst)
        wr_req |-> wr_line == exp_wb_line)
        else report_mismatch("wr_line", $sampled(wr_line), $sampled(exp_wb_line));

    wb_needed: assert property (@(posedge clk) disable iff (rst)
        wr_req |-> line_stored[wb_line])
        else report_problem("write-back of a line with no store since its refill");

    repl_wb_addr: assert property (@(posedge clk) disable iff (rst)
        check_repl && wr_req |-> wr_addr.raw == REPL_B)
        else report_mismatch("wr_addr", 128'($sampled(wr_addr.raw)), 128'(REPL_B));

    repl_rd_addr: assert property (@(posedge clk) disable iff (rst)
        check_repl && rd_req |-> rd_addr.raw == REPL_C)
        else report_mismatch("rd_addr", 128'($sampled(rd_addr.raw)), 128'(REPL_C));

    repl_order: assert property (@(posedge clk) disable iff (rst)
        check_repl && rd_req |-> wb_seen)
        else report_problem("new line was read before the dirty victim was written back");

    initial begin
        logic [31:0] line_addr;
        logic [31:0] word_addr;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = MEM_FILL + i;
        end
        rst        = 1'b1;
        req        = 1'b0;
        cpu_req    = '0;
        check_repl = 1'b0;
        line_addr  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        // random traffic over 8 sets and 4 tags, half the time on the previous line
        for (int n = 0; n < N_RAND; n++) begin
            if (n == 0 || take_bits(1) != 0) begin
                line_addr = {20'h0, 2'(take_bits(2)), 3'b000, 3'(take_bits(3)), 4'h0};
            end
            word_addr = {line_addr[31:4], 2'(take_bits(2)), 2'b00};
            issue(1'(take_bits(1)), word_addr, take_bits(32), 4'(take_bits(4)));
        end
        wait_idle();

        // A, dirty B, A again; C must evict B
        issue(1'b0, REPL_A, '0, 4'h0);
        issue(1'b1, REPL_B + 4, take_bits(32), 4'b0110);
        issue(1'b0, REPL_A, '0, 4'h0);
        wait_idle();
        check_repl <= 1'b1;
        issue(1'b0, REPL_C + 8, '0, 4'h0);
        wait_idle();
        check_repl <= 1'b0;
        // stored bytes must survive the eviction
        issue(1'b0, REPL_B + 4, '0, 4'h0);
        wait_idle();
        @(negedge clk);
        if (load_pending) begin
            report_problem("a load never returned its data");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    // watchdog sized for every request missing with a dirty victim
    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + TOTAL_REQ * WORST_MISS));
        report_problem("timeout, the cache stopped making progress");
    end

endmodule

/* tb/mem_model.sv */
`timescale 1ns/10ps

module mem_model import dcache_pkg::*; #(
    parameter int    WORDS = 1024,
    parameter word_t FILL  = 32'h0
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output logic  rd_rdy,
    output logic  ret_valid,
    output line_t ret_line,
    input  logic  wr_req,
    input  addr_t wr_addr,
    input  line_t wr_line,
    output logic  wr_rdy,
    output logic  wr_done
);

    localparam int AW = $clog2(WORDS);

    word_t         mem [WORDS];
    logic [15:0]   lfsr = 16'd59110;
    logic [2:0]    rd_wait;
    logic [2:0]    wr_wait;
    logic [AW-3:0] rd_base;
    logic [AW-3:0] wr_base;

    assign rd_base = rd_addr.raw[AW+1:4];
    assign wr_base = wr_addr.raw[AW+1:4];

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [2:0] pick_delay();
        logic [2:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < 3; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[1:0], fb};
        end
        return v;
    endfunction

    initial begin
        // each word starts as its own word address plus a constant
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = FILL + i;
        end
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_line  = '0;
        wr_rdy    = 1'b0;
        wr_done   = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            wr_rdy    <= 1'b0;
            wr_done   <= 1'b0;
            rd_wait   <= '0;
            wr_wait   <= '0;
        end else begin
            // one-cycle pulses after each handshake
            ret_valid <= rd_req && rd_rdy;
            wr_done   <= wr_req && wr_rdy;
            if (rd_req && rd_rdy) begin
                rd_rdy  <= 1'b0;
                rd_wait <= pick_delay();
                for (int w = 0; w < 4; w++) begin
                    ret_line[32*w +: 32] <= mem[{rd_base, 2'(w)}];
                end
            end else if (rd_req && rd_wait != 3'd0) begin
                rd_wait <= rd_wait - 3'd1;
            end else if (rd_req) begin
                rd_rdy <= 1'b1;
            end
            if (wr_req && wr_rdy) begin
                wr_rdy  <= 1'b0;
                wr_wait <= pick_delay();
                for (int w = 0; w < 4; w++) begin
                    mem[{wr_base, 2'(w)}] <= wr_line[32*w +: 32];
                end
            end else if (wr_req && wr_wait != 3'd0) begin
                wr_wait <= wr_wait - 3'd1;
            end else if (wr_req) begin
                wr_rdy <= 1'b1;
            end
        end
    end

endmodule
